/* include/dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// cache geometry, two ways per set

// byte address
`define DC_ADDR_WIDTH 32

// 16 sets
`define DC_INDEX_WIDTH 4

// 4 words per line
`define DC_WORD_OFFSET_WIDTH 2

`endif

/* logic/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

`include "dcache_settings.svh"

    localparam int ADDR_WIDTH        = `DC_ADDR_WIDTH;
    localparam int INDEX_WIDTH       = `DC_INDEX_WIDTH;
    localparam int WORD_OFFSET_WIDTH = `DC_WORD_OFFSET_WIDTH;
    localparam int BYTE_OFFSET_WIDTH = WORD_OFFSET_WIDTH + 2;   // word offset plus byte in word

    localparam int SETS           = 1 << INDEX_WIDTH;
    localparam int WORDS_PER_LINE = 1 << WORD_OFFSET_WIDTH;
    localparam int LINE_BYTES     = WORDS_PER_LINE * 4;
    localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - BYTE_OFFSET_WIDTH;

    typedef logic [ADDR_WIDTH-1:0]        addr_t;
    typedef logic [31:0]                  word_t;
    typedef logic [3:0]                   strb_t;
    typedef logic [TAG_WIDTH-1:0]         tag_t;
    typedef logic [INDEX_WIDTH-1:0]       index_t;
    typedef logic [WORD_OFFSET_WIDTH-1:0] word_sel_t;
    typedef logic [LINE_BYTES*8-1:0]      line_t;       // word 0 in the low bits
    typedef logic [LINE_BYTES-1:0]        line_strb_t;
    typedef logic                         way_t;

endpackage

`default_nettype wire

/* logic/cache_arrays.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_arrays (
    input  wire                               clk,
    input  wire                               rstn,
    input  wire dcache_pkg::index_t           rd_index,
    input  wire dcache_pkg::index_t           wr_index,
    input  wire dcache_pkg::line_strb_t [1:0] line_we,
    input  wire dcache_pkg::line_t            wr_line,
    input  wire [1:0]                         tag_we,
    input  wire dcache_pkg::tag_t             wr_tag,
    input  wire                               lru_touch,
    input  wire dcache_pkg::way_t             touch_way,
    input  wire                               dirty_set,
    input  wire                               dirty_clear,
    output dcache_pkg::tag_t [1:0]            way_tag,
    output logic [1:0]                        way_valid,
    output dcache_pkg::line_t [1:0]           way_line,
    output dcache_pkg::way_t                  victim_way,
    output logic                              victim_dirty
);
    import dcache_pkg::*;

    tag_t                  tag_mem  [2][SETS];
    line_t                 data_mem [2][SETS];
    logic [1:0][SETS-1:0]  valid_q;
    logic [1:0][SETS-1:0]  dirty_q;
    logic [SETS-1:0]       lru_q;       // way touched last, per set

    ////////////////////////////////////////////////////////////////////////////
    // tag and data storage, read-first

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (line_we[w][b]) begin
                    data_mem[w][wr_index][8*b +: 8] <= wr_line[8*b +: 8];
                end
            end
            if (tag_we[w]) begin
                tag_mem[w][wr_index] <= wr_tag;
            end
            way_line[w]  <= data_mem[w][rd_index];  // old contents on a same-index write
            way_tag[w]   <= tag_mem[w][rd_index];
            way_valid[w] <= valid_q[w][rd_index];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // valid, dirty and lru tables

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (tag_we[w]) begin
                    valid_q[w][wr_index] <= 1'b1;
                end
            end
            if (lru_touch) begin
                lru_q[wr_index] <= touch_way;
            end
            // a store sets the bit, a clean refill clears it
            if (dirty_set || dirty_clear) begin
                dirty_q[touch_way][wr_index] <= dirty_set;
            end
        end
    end

    // replace the way that was not used last
    assign victim_way   = ~lru_q[wr_index];
    assign victim_dirty = dirty_q[victim_way][wr_index];

endmodule

`default_nettype wire

/* logic/cache_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_controller (
    input  wire                               clk,
    input  wire                               rstn,
    // processor port
    input  wire dcache_pkg::addr_t            addr,
    input  wire                               rvalid,
    input  wire                               wvalid,
    input  wire dcache_pkg::word_t            wdata,
    input  wire dcache_pkg::strb_t            wstrb,
    output logic                              rready,
    output logic                              wready,
    output dcache_pkg::word_t                 rdata,
    // array controls
    output dcache_pkg::index_t                rd_index,
    output dcache_pkg::index_t                wr_index,
    output dcache_pkg::line_strb_t [1:0]      line_we,
    output dcache_pkg::line_t                 wr_line,
    output logic [1:0]                        tag_we,
    output dcache_pkg::tag_t                  wr_tag,
    output logic                              lru_touch,
    output dcache_pkg::way_t                  touch_way,
    output logic                              dirty_set,
    output logic                              dirty_clear,
    // array outputs
    input  wire dcache_pkg::tag_t [1:0]       way_tag,
    input  wire [1:0]                         way_valid,
    input  wire dcache_pkg::line_t [1:0]      way_line,
    input  wire dcache_pkg::way_t             victim_way,
    // memory read channel
    output logic                              d_rvalid,
    input  wire                               d_rready,
    output dcache_pkg::addr_t                 d_raddr,
    input  wire dcache_pkg::word_t            d_rdata,
    input  wire                               d_rlast,
    // write-back unit
    output logic                              evict_start,
    output dcache_pkg::addr_t                 evict_addr,
    output dcache_pkg::line_t                 evict_line,
    output logic                              evict_clear,
    input  wire                               evict_done
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {IDLE, LOOKUP, REFILL, INSTALL, WAIT_EVICT} state_t;

    state_t     state;
    state_t     state_nxt;
    logic       take_req;
    addr_t      req_addr;
    word_t      req_wdata;
    strb_t      req_wstrb;
    logic       req_write;
    tag_t       req_tag;
    index_t     req_index;
    word_sel_t  req_word;
    logic [1:0] hit;
    way_t       hit_way;
    line_t      ret_line;
    line_t      rd_line;
    line_strb_t store_mask;

    ////////////////////////////////////////////////////////////////////////////
    // request register and address fields

    always_ff @(posedge clk) begin
        if (take_req) begin
            req_addr  <= addr;
            req_wdata <= wdata;
            req_wstrb <= wstrb;
            req_write <= wvalid;
        end
    end

    assign req_tag   = req_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign req_index = req_addr[BYTE_OFFSET_WIDTH +: INDEX_WIDTH];
    assign req_word  = req_addr[2 +: WORD_OFFSET_WIDTH];

    assign rd_index = addr[BYTE_OFFSET_WIDTH +: INDEX_WIDTH];   // arrays read the live address
    assign wr_index = req_index;
    assign wr_tag   = req_tag;

    // hit check and read select
    assign hit[0]  = way_valid[0] && (way_tag[0] == req_tag);
    assign hit[1]  = way_valid[1] && (way_tag[1] == req_tag);
    assign hit_way = hit[1];
    assign rd_line = (state == WAIT_EVICT) ? ret_line : way_line[hit_way];
    assign rdata   = rd_line[32*req_word +: 32];

    ////////////////////////////////////////////////////////////////////////////
    // refill and byte merge

    always_ff @(posedge clk) begin
        if (d_rvalid && d_rready) begin
            ret_line <= {d_rdata, ret_line[$bits(line_t)-1:32]};   // first beat ends up lowest
        end
    end

    assign store_mask = req_write ? (line_strb_t'(req_wstrb) << {req_word, 2'b00}) : '0;

    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            wr_line[8*b +: 8] = store_mask[b] ? req_wdata[8*(b%4) +: 8] : ret_line[8*b +: 8];
        end
    end

    assign d_rvalid = (state == REFILL);
    assign d_raddr  = {req_addr[ADDR_WIDTH-1:BYTE_OFFSET_WIDTH], {BYTE_OFFSET_WIDTH{1'b0}}};

    // victim line for the write-back unit
    assign evict_addr = {way_tag[victim_way], req_index, {BYTE_OFFSET_WIDTH{1'b0}}};
    assign evict_line = way_line[victim_way];

    ////////////////////////////////////////////////////////////////////////////
    // main FSM

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt   = state;
        take_req    = 1'b0;
        rready      = 1'b0;
        wready      = 1'b0;
        line_we     = '0;
        tag_we      = '0;
        lru_touch   = 1'b0;
        touch_way   = victim_way;
        dirty_set   = 1'b0;
        dirty_clear = 1'b0;
        evict_start = 1'b0;
        evict_clear = 1'b0;
        case (state)
            IDLE: begin
                take_req = 1'b1;
            end
            LOOKUP: begin
                if (|hit) begin
                    rready           = !req_write;
                    wready           = req_write;
                    line_we[hit_way] = store_mask;
                    lru_touch        = 1'b1;
                    touch_way        = hit_way;
                    dirty_set        = req_write;
                    // merged bytes are not readable yet, next request waits in idle
                    take_req         = !req_write;
                    state_nxt        = IDLE;
                end else begin
                    evict_start = 1'b1;     // victim leaves while the refill runs
                    state_nxt   = REFILL;
                end
            end
            REFILL: begin
                if (d_rready && d_rlast) begin
                    state_nxt = INSTALL;
                end
            end
            INSTALL: begin
                line_we[victim_way] = '1;
                tag_we[victim_way]  = 1'b1;
                lru_touch           = 1'b1;
                dirty_set           = req_write;    // a write miss installs a dirty line
                dirty_clear         = !req_write;
                state_nxt           = WAIT_EVICT;
            end
            WAIT_EVICT: begin
                if (evict_done) begin
                    rready      = !req_write;
                    wready      = req_write;
                    evict_clear = 1'b1;
                    take_req    = 1'b1;
                    state_nxt   = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
        if (take_req && (rvalid || wvalid)) begin
            state_nxt = LOOKUP;
        end
    end

endmodule

`default_nettype wire

/* logic/writeback_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module writeback_unit (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    evict_start,
    input  wire                    evict_dirty,
    input  wire dcache_pkg::addr_t evict_addr,
    input  wire dcache_pkg::line_t evict_line,
    input  wire                    evict_clear,
    output logic                   evict_done,
    // memory write channel
    output logic                   d_wvalid,
    input  wire                    d_wready,
    output dcache_pkg::addr_t      d_waddr,
    output dcache_pkg::word_t      d_wdata,
    output logic                   d_wlast,
    input  wire                    d_bvalid,
    output logic                   d_bready
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {WB_IDLE, WB_WRITE, WB_RESP, WB_DONE} wb_state_t;

    wb_state_t state;
    line_t     line_buf;
    word_sel_t beat_cnt;
    logic      beat_ok;

    assign beat_ok    = d_wvalid && d_wready;
    assign d_wvalid   = (state == WB_WRITE);
    assign d_bready   = (state == WB_WRITE) || (state == WB_RESP);
    assign d_wlast    = d_wvalid && (beat_cnt == word_sel_t'(WORDS_PER_LINE - 1));
    assign d_wdata    = line_buf[31:0];
    assign evict_done = (state == WB_DONE);

    // line and address buffer, one word out per accepted beat
    always_ff @(posedge clk) begin
        if (evict_start) begin
            line_buf <= evict_line;
            d_waddr  <= evict_addr;
        end else if (beat_ok) begin
            line_buf <= line_buf >> 32;
            d_waddr  <= d_waddr + addr_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= WB_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                WB_IDLE: begin
                    if (evict_start) begin
                        beat_cnt <= '0;
                        state    <= evict_dirty ? WB_WRITE : WB_DONE;  // clean victim, nothing to send
                    end
                end
                WB_WRITE: begin
                    if (beat_ok) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (d_wlast) begin
                            state <= d_bvalid ? WB_DONE : WB_RESP;
                        end
                    end
                end
                WB_RESP: begin
                    if (d_bvalid) begin
                        state <= WB_DONE;
                    end
                end
                default: begin
                    // held until the controller has seen it
                    if (evict_clear) begin
                        state <= WB_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/dcache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_top (
    input  wire                    clk,
    input  wire                    rstn,
    // processor port
    input  wire dcache_pkg::addr_t addr,
    input  wire                    rvalid,
    output logic                   rready,
    output dcache_pkg::word_t      rdata,
    input  wire                    wvalid,
    output logic                   wready,
    input  wire dcache_pkg::word_t wdata,
    input  wire dcache_pkg::strb_t wstrb,
    // memory read channel, WORDS_PER_LINE beats of one word
    output logic                   d_rvalid,
    input  wire                    d_rready,
    output dcache_pkg::addr_t      d_raddr,
    input  wire dcache_pkg::word_t d_rdata,
    input  wire                    d_rlast,
    // memory write channel, all bytes on every beat
    output logic                   d_wvalid,
    input  wire                    d_wready,
    output dcache_pkg::addr_t      d_waddr,
    output dcache_pkg::word_t      d_wdata,
    output logic                   d_wlast,
    input  wire                    d_bvalid,
    output logic                   d_bready
);
    import dcache_pkg::*;

    index_t           rd_index;
    index_t           wr_index;
    line_strb_t [1:0] line_we;
    line_t            wr_line;
    logic [1:0]       tag_we;
    tag_t             wr_tag;
    logic             lru_touch;
    way_t             touch_way;
    logic             dirty_set;
    logic             dirty_clear;
    tag_t [1:0]       way_tag;
    logic [1:0]       way_valid;
    line_t [1:0]      way_line;
    way_t             victim_way;
    logic             victim_dirty;
    logic             evict_start;
    addr_t            evict_addr;
    line_t            evict_line;
    logic             evict_clear;
    logic             evict_done;

    // port names match the wires above
    cache_controller u_cache_controller (.*);

    cache_arrays u_cache_arrays (.*);

    writeback_unit u_writeback_unit (
        .evict_dirty (victim_dirty),
        .*
    );

endmodule

`default_nettype wire

/* testbench/tb_dcache.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int MEM_WORDS   = 1024;   // covers byte addresses below 0x1000
    localparam int REQ_TIMEOUT = 200;
    localparam int N_REQ       = 12;

    typedef struct packed {
        logic       write;
        addr_t      addr;
        word_t      wdata;
        strb_t      wstrb;
        logic       refill;         // a read burst is expected
        logic [2:0] beats;          // write-back beats expected
        addr_t      evict_base;     // line address of a dirty victim
    } req_entry_t;

    // everything lands in set 3, tags 0 to 3
    req_entry_t stim [N_REQ] = '{
        '{1'b0, 32'h030, 32'h0, 4'h0, 1'b1, 3'd0, 32'h0},            // clean miss, fills way 1
        '{1'b0, 32'h038, 32'h0, 4'h0, 1'b0, 3'd0, 32'h0},            // same line
        '{1'b1, 32'h034, 32'hA5A5_5A5A, 4'b0101, 1'b0, 3'd0, 32'h0}, // partial write hit
        '{1'b0, 32'h034, 32'h0, 4'h0, 1'b0, 3'd0, 32'h0},
        '{1'b1, 32'h134, 32'h1234_5678, 4'b0110, 1'b1, 3'd0, 32'h0}, // write miss, way 0
        '{1'b0, 32'h134, 32'h0, 4'h0, 1'b0, 3'd0, 32'h0},
        '{1'b0, 32'h03C, 32'h0, 4'h0, 1'b0, 3'd0, 32'h0},            // way 0 becomes lru
        '{1'b0, 32'h230, 32'h0, 4'h0, 1'b1, 3'd4, 32'h130},          // evicts dirty tag 1
        '{1'b0, 32'h034, 32'h0, 4'h0, 1'b0, 3'd0, 32'h0},            // survivor still hits
        '{1'b0, 32'h134, 32'h0, 4'h0, 1'b1, 3'd0, 32'h0},            // back from memory
        '{1'b0, 32'h330, 32'h0, 4'h0, 1'b1, 3'd4, 32'h030},          // evicts dirty tag 0
        '{1'b0, 32'h034, 32'h0, 4'h0, 1'b1, 3'd0, 32'h0}
    };

    logic  clk;
    logic  rstn;
    addr_t addr;
    logic  rvalid;
    logic  rready;
    word_t rdata;
    logic  wvalid;
    logic  wready;
    word_t wdata;
    strb_t wstrb;
    logic  d_rvalid;
    logic  d_rready;
    addr_t d_raddr;
    word_t d_rdata;
    logic  d_rlast;
    logic  d_wvalid;
    logic  d_wready;
    addr_t d_waddr;
    word_t d_wdata;
    logic  d_wlast;
    logic  d_bvalid;
    logic  d_bready;

    word_t mem    [MEM_WORDS];
    word_t shadow [MEM_WORDS];      // what the processor should see
    int    rd_beat;
    int    read_bursts;
    addr_t last_raddr;
    int    lasts_seen;
    int    resps_sent;
    addr_t wb_addr_q [$];
    word_t wb_data_q [$];
    logic  wb_last_q [$];

    dcache_top u_dcache_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int mem_index(addr_t a);
        return int'(a[11:2]);
    endfunction

    function automatic word_t merge_store(word_t old, word_t data, strb_t strb);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // failure reporting and compares

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH at %0t ns: %s got %08h expected %08h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_addr(addr_t got, addr_t exp, string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH at %0t ns: %s got %08h expected %08h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_port_idle();
        check_flag(rready, 1'b0, "rready after reset");
        check_flag(wready, 1'b0, "wready after reset");
        check_flag(d_rvalid, 1'b0, "d_rvalid after reset");
        check_flag(d_wvalid, 1'b0, "d_wvalid after reset");
        check_flag(d_wlast, 1'b0, "d_wlast after reset");
        check_flag(d_bready, 1'b0, "d_bready after reset");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // memory model, read bursts and write responses

    initial begin
        d_rready    = 1'b0;
        d_rdata     = '0;
        d_rlast     = 1'b0;
        d_bvalid    = 1'b0;
        rd_beat     = 0;
        read_bursts = 0;
        resps_sent  = 0;
        last_raddr  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (d_rvalid) begin
                if (rd_beat == 0) begin
                    read_bursts = read_bursts + 1;
                    last_raddr  = d_raddr;
                end
                d_rready = 1'b1;
                d_rdata  = mem[mem_index(d_raddr) + rd_beat];
                d_rlast  = (rd_beat == WORDS_PER_LINE - 1);
                rd_beat  = rd_beat + 1;
            end else begin
                d_rready = 1'b0;
                d_rlast  = 1'b0;
                rd_beat  = 0;
            end
            d_bvalid = (lasts_seen != resps_sent);  // one cycle after the last beat
            if (d_bvalid) begin
                resps_sent = resps_sent + 1;
            end
        end
    end

    // write beats are taken mid-cycle while the beat is still offered
    initial begin
        void'($urandom(93));
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $urandom();
        end
        d_wready   = 1'b1;
        lasts_seen = 0;
        forever begin
            @(negedge clk);
            if (d_wvalid && d_wready) begin
                check_flag(d_bready, 1'b1, "d_bready during write");
                mem[mem_index(d_waddr)] = d_wdata;
                wb_addr_q.push_back(d_waddr);
                wb_data_q.push_back(d_wdata);
                wb_last_q.push_back(d_wlast);
                if (d_wlast) begin
                    lasts_seen = lasts_seen + 1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // one table entry: request, wait for ready, check

    task automatic run_request(req_entry_t e);
        int    cycles;
        int    bursts_before;
        int    beats_before;
        int    new_beats;
        word_t got;
        bursts_before = read_bursts;
        beats_before  = wb_addr_q.size();
        addr   = e.addr;
        wdata  = e.wdata;
        wstrb  = e.write ? e.wstrb : 4'h0;   // reads carry no strobes
        rvalid = !e.write;
        wvalid = e.write;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles = cycles + 1;
            if (cycles > REQ_TIMEOUT) begin
                stop_with_failure($sformatf("request to %08h was never answered", e.addr));
            end
        end while (!rready && !wready);
        got    = rdata;
        rvalid = 1'b0;
        wvalid = 1'b0;
        check_flag(rready, !e.write, "rready");
        check_flag(wready, e.write, "wready");
        if (!e.write) begin
            check_word(got, shadow[mem_index(e.addr)], "read data");
        end
        check_flag(read_bursts != bursts_before, e.refill, "read burst seen");
        if (e.refill) begin
            check_addr(last_raddr, {e.addr[31:4], 4'h0}, "refill address");
        end
        new_beats = wb_addr_q.size() - beats_before;
        if (new_beats != int'(e.beats)) begin
            stop_with_failure($sformatf("request to %08h gave %0d write-back beats, not %0d",
                                        e.addr, new_beats, e.beats));
        end
        for (int k = 0; k < new_beats; k++) begin
            check_addr(wb_addr_q[beats_before + k], e.evict_base + addr_t'(4 * k), "d_waddr");
            check_word(wb_data_q[beats_before + k], shadow[mem_index(e.evict_base) + k],
                       "d_wdata");
            check_flag(wb_last_q[beats_before + k], k == WORDS_PER_LINE - 1, "d_wlast");
        end
        if (e.write) begin
            shadow[mem_index(e.addr)] = merge_store(shadow[mem_index(e.addr)], e.wdata,
                                                    e.wstrb);
        end
        @(posedge clk);     // valids stay low for one cycle
        #1;
    endtask

    initial begin
        rstn   = 1'b0;
        addr   = '0;
        rvalid = 1'b0;
        wvalid = 1'b0;
        wdata  = '0;
        wstrb  = '0;
        repeat (2) begin
            @(posedge clk);
            #1;
            check_port_idle();
        end
        rstn = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = mem[i];
        end
        @(posedge clk);
        #1;
        check_port_idle();
        for (int i = 0; i < N_REQ; i++) begin
            run_request(stim[i]);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
logic/dcache_pkg.sv
logic/cache_arrays.sv
logic/cache_controller.sv
logic/writeback_unit.sv
logic/dcache_top.sv
testbench/tb_dcache.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -f sources.f --top-module tb_dcache -Mdir obj_dir
	./obj_dir/Vtb_dcache

clean:
	rm -rf obj_dir
